//--- design/ai_cu_top.sv
`timescale 1ns/10ps
`default_nettype none

module ai_cu_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_wr,
    input  logic [cu_pkg::CSR_AW-1:0] csr_addr,
    input  logic [31:0]               csr_wdata,
    input  logic                      host_mem_wr,
    input  logic [cu_pkg::ADDR_W-1:0] host_mem_addr,
    input  logic [cu_pkg::DATA_W-1:0] host_mem_wdata,
    input  logic [cu_pkg::ADDR_W-1:0] host_mem_raddr,
    output logic [cu_pkg::DATA_W-1:0] host_mem_rdata,
    output logic                      layer_done,
    output logic                      busy,
    output logic                      phase_fetch,
    output logic                      phase_compute,
    output logic                      phase_writeback
);
    import cu_pkg::*;

    logic [ADDR_W-1:0] ifm_base;
    logic [ADDR_W-1:0] wgt_base;
    logic [ADDR_W-1:0] ofm_base;
    logic [LEN_W-1:0]  ifm_len;
    logic [LEN_W-1:0]  wgt_len;
    logic [LEN_W-1:0]  ofm_len;
    logic              start_cmd;
    logic              seq_start;
    logic [LEN_W-1:0]  seq_len;
    logic              seq_done;
    cu_state_t         state;

    dma_ch_if   dma_ch ();
    buf_port_if buf_port ();

    csr_bank u_csr (
        .clk       (clk),
        .rst       (rst),
        .csr_wr    (csr_wr),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .ifm_base  (ifm_base),
        .wgt_base  (wgt_base),
        .ofm_base  (ofm_base),
        .ifm_len   (ifm_len),
        .wgt_len   (wgt_len),
        .ofm_len   (ofm_len),
        .start_cmd (start_cmd)
    );

    layer_ctrl_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start_cmd  (start_cmd),
        .ifm_base   (ifm_base),
        .wgt_base   (wgt_base),
        .ofm_base   (ofm_base),
        .ifm_len    (ifm_len),
        .wgt_len    (wgt_len),
        .ofm_len    (ofm_len),
        .dma        (dma_ch.ctrl),
        .seq_start  (seq_start),
        .seq_len    (seq_len),
        .seq_done   (seq_done),
        .layer_done (layer_done),
        .state      (state)
    );

    dma_engine u_dma (
        .clk            (clk),
        .rst            (rst),
        .dma            (dma_ch.engine),
        .bufp           (buf_port.engine),
        .host_mem_wr    (host_mem_wr),
        .host_mem_addr  (host_mem_addr),
        .host_mem_wdata (host_mem_wdata),
        .host_mem_raddr (host_mem_raddr),
        .host_mem_rdata (host_mem_rdata)
    );

    mac_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .bufp      (buf_port.seq),
        .seq_start (seq_start),
        .seq_len   (seq_len),
        .seq_done  (seq_done)
    );

    // phase decode from the controller state
    assign busy            = (state != S_IDLE);
    assign phase_fetch     = (state == S_FETCH_IFM) || (state == S_FETCH_WGT);
    assign phase_compute   = (state == S_START_SEQ) || (state == S_WAIT_SEQ);
    assign phase_writeback = (state == S_WRITEBACK);

endmodule

`default_nettype wire

//--- design/buf_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface buf_port_if;
    import cu_pkg::*;

    // fill path into ifm / wgt buffers
    logic              fill_en;
    buf_sel_t          fill_target;
    logic [IDX_W-1:0]  fill_idx;
    logic [DATA_W-1:0] fill_data;

    // drain path out of the ofm buffer
    logic [IDX_W-1:0]  drain_idx;
    logic [DATA_W-1:0] drain_data;

    modport engine (
        output fill_en, fill_target, fill_idx, fill_data, drain_idx,
        input  drain_data
    );

    modport seq (
        input  fill_en, fill_target, fill_idx, fill_data, drain_idx,
        output drain_data
    );

endinterface

`default_nettype wire

//--- design/csr_bank.sv
`timescale 1ns/10ps
`default_nettype none

module csr_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_wr,
    input  logic [cu_pkg::CSR_AW-1:0] csr_addr,
    input  logic [31:0]               csr_wdata,
    output logic [cu_pkg::ADDR_W-1:0] ifm_base,
    output logic [cu_pkg::ADDR_W-1:0] wgt_base,
    output logic [cu_pkg::ADDR_W-1:0] ofm_base,
    output logic [cu_pkg::LEN_W-1:0]  ifm_len,
    output logic [cu_pkg::LEN_W-1:0]  wgt_len,
    output logic [cu_pkg::LEN_W-1:0]  ofm_len,
    output logic                      start_cmd
);
    import cu_pkg::*;

    // config registers keep only their field width
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ifm_base <= '0;
            wgt_base <= '0;
            ofm_base <= '0;
            ifm_len  <= '0;
            wgt_len  <= '0;
            ofm_len  <= '0;
        end else if (csr_wr) begin
            case (csr_addr)
                CSR_IFM_BASE: ifm_base <= csr_wdata[ADDR_W-1:0];
                CSR_WGT_BASE: wgt_base <= csr_wdata[ADDR_W-1:0];
                CSR_OFM_BASE: ofm_base <= csr_wdata[ADDR_W-1:0];
                CSR_IFM_LEN:  ifm_len  <= csr_wdata[LEN_W-1:0];
                CSR_WGT_LEN:  wgt_len  <= csr_wdata[LEN_W-1:0];
                CSR_OFM_LEN:  ofm_len  <= csr_wdata[LEN_W-1:0];
                default: ;
            endcase
        end
    end

    // start strobe goes high one cycle after the ctrl write
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            start_cmd <= 1'b0;
        end else begin
            start_cmd <= csr_wr && (csr_addr == CSR_CTRL) && csr_wdata[0];
        end
    end

endmodule

`default_nettype wire

//--- design/cu_pkg.sv
`default_nettype none

package cu_pkg;

    ////////////////////////////////////////
    // widths and depths
    ////////////////////////////////////////
    localparam int ADDR_W    = 8;
    localparam int LEN_W     = 6;
    localparam int DATA_W    = 16;
    localparam int MEM_DEPTH = 256;
    localparam int BUF_DEPTH = 32;
    localparam int IDX_W     = $clog2(BUF_DEPTH);

    ////////////////////////////////////////
    // csr map
    ////////////////////////////////////////
    localparam int CSR_AW = 3;

    localparam logic [CSR_AW-1:0] CSR_CTRL     = 3'd0;
    localparam logic [CSR_AW-1:0] CSR_IFM_BASE = 3'd1;
    localparam logic [CSR_AW-1:0] CSR_WGT_BASE = 3'd2;
    localparam logic [CSR_AW-1:0] CSR_OFM_BASE = 3'd3;
    localparam logic [CSR_AW-1:0] CSR_IFM_LEN  = 3'd4;
    localparam logic [CSR_AW-1:0] CSR_WGT_LEN  = 3'd5;
    localparam logic [CSR_AW-1:0] CSR_OFM_LEN  = 3'd6;

    // buffer a read transfer fills
    typedef enum logic {
        BUF_IFM,
        BUF_WGT
    } buf_sel_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH_IFM,
        S_FETCH_WGT,
        S_START_SEQ,
        S_WAIT_SEQ,
        S_WRITEBACK,
        S_DONE
    } cu_state_t;

endpackage

`default_nettype wire

//--- design/dma_ch_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dma_ch_if;
    import cu_pkg::*;

    // request side is held until done
    logic              req;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    buf_sel_t          target;

    // one-cycle completion strobe
    logic              done;

    modport ctrl (
        output req, write, addr, len, target,
        input  done
    );

    modport engine (
        input  req, write, addr, len, target,
        output done
    );

endinterface

`default_nettype wire

//--- design/dma_engine.sv
`timescale 1ns/10ps
`default_nettype none

module dma_engine (
    input  logic                      clk,
    input  logic                      rst,
    dma_ch_if.engine                  dma,
    buf_port_if.engine                bufp,
    input  logic                      host_mem_wr,
    input  logic [cu_pkg::ADDR_W-1:0] host_mem_addr,
    input  logic [cu_pkg::DATA_W-1:0] host_mem_wdata,
    input  logic [cu_pkg::ADDR_W-1:0] host_mem_raddr,
    output logic [cu_pkg::DATA_W-1:0] host_mem_rdata
);
    import cu_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    logic              active;
    logic              xfer_write;
    logic [ADDR_W-1:0] xfer_base;
    logic [LEN_W-1:0]  xfer_len;
    buf_sel_t          xfer_target;
    logic [LEN_W-1:0]  cnt;
    logic [ADDR_W-1:0] cur_addr;
    logic              moving;

    ////////////////////////////////////////
    // transfer control
    ////////////////////////////////////////
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active      <= 1'b0;
            xfer_write  <= 1'b0;
            xfer_base   <= '0;
            xfer_len    <= '0;
            xfer_target <= BUF_IFM;
            cnt         <= '0;
        end else if (!active) begin
            // only pick up a request while idle
            if (dma.req) begin
                active      <= 1'b1;
                xfer_write  <= dma.write;
                xfer_base   <= dma.addr;
                xfer_len    <= dma.len;
                xfer_target <= dma.target;
                cnt         <= '0;
            end
        end else if (moving) begin
            cnt <= cnt + 1'b1;
        end else begin
            active <= 1'b0;
        end
    end

    assign moving   = active && (cnt != xfer_len);
    assign dma.done = active && (cnt == xfer_len);

    // wraps modulo MEM_DEPTH
    assign cur_addr = xfer_base + ADDR_W'(cnt);

    assign bufp.fill_en     = moving && !xfer_write;
    assign bufp.fill_target = xfer_target;
    assign bufp.fill_idx    = cnt[IDX_W-1:0];
    assign bufp.fill_data   = mem[cur_addr];
    assign bufp.drain_idx   = cnt[IDX_W-1:0];

    ////////////////////////////////////////
    // data memory
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (moving && xfer_write) begin
            mem[cur_addr] <= bufp.drain_data;
        end else if (host_mem_wr) begin
            mem[host_mem_addr] <= host_mem_wdata;
        end
    end

    assign host_mem_rdata = mem[host_mem_raddr];

endmodule

`default_nettype wire

//--- design/layer_ctrl_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module layer_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_cmd,
    input  logic [cu_pkg::ADDR_W-1:0] ifm_base,
    input  logic [cu_pkg::ADDR_W-1:0] wgt_base,
    input  logic [cu_pkg::ADDR_W-1:0] ofm_base,
    input  logic [cu_pkg::LEN_W-1:0]  ifm_len,
    input  logic [cu_pkg::LEN_W-1:0]  wgt_len,
    input  logic [cu_pkg::LEN_W-1:0]  ofm_len,
    dma_ch_if.ctrl                    dma,
    output logic                      seq_start,
    output logic [cu_pkg::LEN_W-1:0]  seq_len,
    input  logic                      seq_done,
    output logic                      layer_done,
    output cu_pkg::cu_state_t         state
);
    import cu_pkg::*;

    cu_state_t n_state;
    logic      dma_gap;
    logic      dma_phase;

    // buffers hold BUF_DEPTH entries at most
    function automatic logic [LEN_W-1:0] clamp_len(input logic [LEN_W-1:0] len);
        if (len > LEN_W'(BUF_DEPTH)) begin
            return LEN_W'(BUF_DEPTH);
        end
        return len;
    endfunction

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= n_state;
        end
    end

    // req goes low for the cycle after each done
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            dma_gap <= 1'b0;
        end else begin
            dma_gap <= dma.done;
        end
    end

    assign dma_phase = (state == S_FETCH_IFM) || (state == S_FETCH_WGT)
                    || (state == S_WRITEBACK);

    assign dma.req    = dma_phase && !dma_gap;
    assign seq_start  = (state == S_START_SEQ);
    assign seq_len    = clamp_len(ofm_len);
    assign layer_done = (state == S_DONE);

    ////////////////////////////////////////
    // next state and channel fields
    ////////////////////////////////////////
    always_comb begin
        n_state    = state;
        dma.write  = 1'b0;
        dma.addr   = '0;
        dma.len    = '0;
        dma.target = BUF_IFM;

        case (state)
            S_IDLE: begin
                if (start_cmd) begin
                    n_state = S_FETCH_IFM;
                end
            end

            S_FETCH_IFM: begin
                dma.addr   = ifm_base;
                dma.len    = clamp_len(ifm_len);
                dma.target = BUF_IFM;
                if (dma.done) begin
                    n_state = S_FETCH_WGT;
                end
            end

            S_FETCH_WGT: begin
                dma.addr   = wgt_base;
                dma.len    = clamp_len(wgt_len);
                dma.target = BUF_WGT;
                if (dma.done) begin
                    n_state = S_START_SEQ;
                end
            end

            S_START_SEQ: begin
                n_state = S_WAIT_SEQ;
            end

            S_WAIT_SEQ: begin
                if (seq_done) begin
                    n_state = S_WRITEBACK;
                end
            end

            S_WRITEBACK: begin
                dma.write = 1'b1;
                dma.addr  = ofm_base;
                dma.len   = clamp_len(ofm_len);
                if (dma.done) begin
                    n_state = S_DONE;
                end
            end

            S_DONE: begin
                n_state = S_IDLE;
            end

            default: begin
                n_state = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/mac_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module mac_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    buf_port_if.seq                  bufp,
    input  logic                     seq_start,
    input  logic [cu_pkg::LEN_W-1:0] seq_len,
    output logic                     seq_done
);
    import cu_pkg::*;

    logic [DATA_W-1:0] ifm_buf [BUF_DEPTH];
    logic [DATA_W-1:0] wgt_buf [BUF_DEPTH];
    logic [DATA_W-1:0] ofm_buf [BUF_DEPTH];

    logic              running;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  cnt;
    logic              step;
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] prod;

    // fill from the dma engine
    always_ff @(posedge clk) begin
        if (bufp.fill_en) begin
            if (bufp.fill_target == BUF_IFM) begin
                ifm_buf[bufp.fill_idx] <= bufp.fill_data;
            end else begin
                wgt_buf[bufp.fill_idx] <= bufp.fill_data;
            end
        end
    end

    ////////////////////////////////////////
    // element sequence
    ////////////////////////////////////////
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            len_q   <= '0;
            cnt     <= '0;
        end else if (seq_start) begin
            running <= 1'b1;
            len_q   <= seq_len;
            cnt     <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end else if (seq_done) begin
            running <= 1'b0;
        end
    end

    assign step     = running && (cnt != len_q);
    assign seq_done = running && (cnt == len_q);
    assign idx      = cnt[IDX_W-1:0];

    // low DATA_W bits of the product only
    assign prod = ifm_buf[idx] * wgt_buf[idx];

    always_ff @(posedge clk) begin
        if (step) begin
            ofm_buf[idx] <= prod;
        end
    end

    assign bufp.drain_data = ofm_buf[bufp.drain_idx];

endmodule

`default_nettype wire

//--- flist.f
design/cu_pkg.sv
design/dma_ch_if.sv
design/buf_port_if.sv
design/csr_bank.sv
design/layer_ctrl_fsm.sv
design/dma_engine.sv
design/mac_sequencer.sv
design/ai_cu_top.sv
tb/tb_ai_cu.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ai_cu \
    -f flist.f

./obj_dir/Vtb_ai_cu | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- tb/tb_ai_cu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ai_cu;
    import cu_pkg::*;

    // fill, five readbacks of the whole memory and five layers of
    // at most ~200 cycles each come to about 2600 cycles
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int NUM_LAYERS     = 5;

    logic              clk;
    logic              rst;
    logic              csr_wr;
    logic [CSR_AW-1:0] csr_addr;
    logic [31:0]       csr_wdata;
    logic              host_mem_wr;
    logic [ADDR_W-1:0] host_mem_addr;
    logic [DATA_W-1:0] host_mem_wdata;
    logic [ADDR_W-1:0] host_mem_raddr;
    logic [DATA_W-1:0] host_mem_rdata;
    logic              layer_done;
    logic              busy;
    logic              phase_fetch;
    logic              phase_compute;
    logic              phase_writeback;

    // expected memory and buffer contents
    logic [DATA_W-1:0] shadow_mem [MEM_DEPTH];
    logic [DATA_W-1:0] ifm_sh [BUF_DEPTH];
    logic [DATA_W-1:0] wgt_sh [BUF_DEPTH];

    logic [31:0] rng_state;
    int          cycle_count   = 0;
    int          done_count    = 0;
    int          last_phase    = 0;
    int          cur_phase;
    logic [2:0]  phases;
    logic [2:0]  seen_phases   = 3'b000;
    logic        prev_done     = 1'b0;
    logic        prev_busy     = 1'b0;
    bit          start_written = 1'b0;

    event check_go;
    event check_ok;

    ai_cu_top dut (
        .clk             (clk),
        .rst             (rst),
        .csr_wr          (csr_wr),
        .csr_addr        (csr_addr),
        .csr_wdata       (csr_wdata),
        .host_mem_wr     (host_mem_wr),
        .host_mem_addr   (host_mem_addr),
        .host_mem_wdata  (host_mem_wdata),
        .host_mem_raddr  (host_mem_raddr),
        .host_mem_rdata  (host_mem_rdata),
        .layer_done      (layer_done),
        .busy            (busy),
        .phase_fetch     (phase_fetch),
        .phase_compute   (phase_compute),
        .phase_writeback (phase_writeback)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers and reference model
    ////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // one output element is the low DATA_W bits of the full product
    function automatic logic [DATA_W-1:0] expected_product(input logic [DATA_W-1:0] a,
                                                           input logic [DATA_W-1:0] b);
        logic [2*DATA_W-1:0] full;
        full = a * b;
        return full[DATA_W-1:0];
    endfunction

    function automatic int clip_to_buffer(input int len);
        return (len > BUF_DEPTH) ? BUF_DEPTH : len;
    endfunction

    // fetch ifm, fetch wgt, compute and write back over persistent buffers
    task automatic model_layer(input int ib, input int wb, input int ob,
                               input int il, input int wl, input int ol);
        int li;
        int lw;
        int lo;
        li = clip_to_buffer(il);
        lw = clip_to_buffer(wl);
        lo = clip_to_buffer(ol);
        for (int i = 0; i < li; i++) begin
            ifm_sh[i] = shadow_mem[(ib + i) % MEM_DEPTH];
        end
        for (int i = 0; i < lw; i++) begin
            wgt_sh[i] = shadow_mem[(wb + i) % MEM_DEPTH];
        end
        for (int i = 0; i < lo; i++) begin
            shadow_mem[(ob + i) % MEM_DEPTH] = expected_product(ifm_sh[i], wgt_sh[i]);
        end
    endtask

    ////////////////////////////////////////
    // host bus drivers
    ////////////////////////////////////////
    task automatic write_csr(input logic [CSR_AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_wr    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
    endtask

    task automatic write_mem(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        host_mem_wr    <= 1'b1;
        host_mem_addr  <= addr;
        host_mem_wdata <= data;
    endtask

    task automatic release_bus();
        @(posedge clk);
        csr_wr      <= 1'b0;
        host_mem_wr <= 1'b0;
    endtask

    task automatic fill_memory();
        logic [DATA_W-1:0] word;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            rng_state = lcg_next(rng_state);
            word = rng_state[30:15];
            write_mem(ADDR_W'(a), word);
            shadow_mem[a] = word;
        end
        release_bus();
    endtask

    task automatic verify_memory();
        -> check_go;
        @(check_ok);
    endtask

    task automatic run_layer(input int ib, input int wb, input int ob,
                             input int il, input int wl, input int ol,
                             input bit extra_start);
        int done_before;
        done_before = done_count;
        write_csr(CSR_IFM_BASE, ib);
        write_csr(CSR_WGT_BASE, wb);
        write_csr(CSR_OFM_BASE, ob);
        write_csr(CSR_IFM_LEN, il);
        write_csr(CSR_WGT_LEN, wl);
        write_csr(CSR_OFM_LEN, ol);
        start_written = 1'b1;
        write_csr(CSR_CTRL, 32'd1);
        release_bus();
        if (extra_start) begin
            // second start lands in the middle of the compute phase
            while (!phase_compute) begin
                @(negedge clk);
            end
            write_csr(CSR_CTRL, 32'd1);
            release_bus();
        end
        while (done_count == done_before) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        assert (done_count == done_before + 1 && !busy) else begin
            abort_run("expected exactly one layer_done and an idle controller after it");
        end
        model_layer(ib, wb, ob, il, wl, ol);
        verify_memory();
    endtask

    ////////////////////////////////////////
    // memory compare process
    ////////////////////////////////////////
    initial begin
        host_mem_raddr = '0;
        forever begin
            @(check_go);
            for (int a = 0; a < MEM_DEPTH; a++) begin
                @(posedge clk);
                host_mem_raddr <= ADDR_W'(a);
                @(negedge clk);
                assert (host_mem_rdata === shadow_mem[a]) else begin
                    abort_run($sformatf("** Error @ %0t: mem[0x%02h] = 0x%04h, expected 0x%04h",
                                        $time, a, host_mem_rdata, shadow_mem[a]));
                end
            end
            -> check_ok;
        end
    end

    ////////////////////////////////////////
    // status and phase monitor
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst) begin
            phases = {phase_writeback, phase_compute, phase_fetch};
            cur_phase = phase_writeback ? 3 : (phase_compute ? 2 : (phase_fetch ? 1 : 0));

            assert (start_written || !busy) else begin
                abort_run("busy went high before any start was written");
            end
            assert ($countones(phases) <= 1) else begin
                abort_run("more than one phase strobe high at once");
            end
            assert (busy || (phases == 3'b000 && !layer_done)) else begin
                abort_run("phase strobe or layer_done high while not busy");
            end
            assert (cur_phase == 0 || cur_phase >= last_phase) else begin
                abort_run("phase strobes appeared out of order");
            end
            assert (!(layer_done && prev_done)) else begin
                abort_run("layer_done stayed high for more than one cycle");
            end
            assert (!(prev_busy && !busy) || prev_done) else begin
                abort_run("busy dropped without a layer_done");
            end
            assert (!prev_done || !busy) else begin
                abort_run("busy still high in the cycle after layer_done");
            end

            if (cur_phase != 0) begin
                last_phase = cur_phase;
            end
            seen_phases = seen_phases | phases;

            if (layer_done) begin
                assert (seen_phases == 3'b111) else begin
                    abort_run("layer_done without fetch, compute and writeback phases");
                end
                done_count  = done_count + 1;
                last_phase  = 0;
                seen_phases = 3'b000;
            end
            prev_done = layer_done;
            prev_busy = busy;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        rst            = 1'b1;
        csr_wr         = 1'b0;
        csr_addr       = '0;
        csr_wdata      = '0;
        host_mem_wr    = 1'b0;
        host_mem_addr  = '0;
        host_mem_wdata = '0;
        rng_state      = 32'd14;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // quiet after reset
        repeat (10) begin
            @(negedge clk);
            assert (!layer_done && !busy && !phase_fetch && !phase_compute
                    && !phase_writeback) else begin
                abort_run("status outputs not all low after reset");
            end
        end

        fill_memory();

        // plain 8-element layer
        run_layer(8'h10, 8'h40, 8'h80, 8, 8, 8, 1'b0);
        // start written again while busy
        run_layer(8'h20, 8'h60, 8'hA0, 8, 8, 8, 1'b1);
        // lengths clamped to 32, ifm wraps, ofm overlaps ifm
        run_layer(8'hF0, 8'h30, 8'hF8, 40, 40, 40, 1'b0);
        // shorter ofm over the previous output region
        run_layer(8'h50, 8'h90, 8'hF8, 12, 12, 5, 1'b0);
        // empty layer
        run_layer(8'h33, 8'h44, 8'h55, 0, 0, 0, 1'b0);

        if (done_count == NUM_LAYERS) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run($sformatf("saw %0d layer_done pulses over %0d layers",
                                done_count, NUM_LAYERS));
        end
    end

endmodule

`default_nettype wire
